/* Bender.yml */
package:
  name: l2_ring_cache

export_include_dirs:
  - hw

sources:
  - hw/ringPkg.sv
  - hw/cachePkg.sv
  - hw/tileArray.sv
  - hw/l2LookupStage.sv
  - hw/l2MissEngine.sv
  - hw/l2RingResponder.sv
  - hw/l2RingCache.sv
  - target: test
    files:
      - testbench/ddrTileModel.sv
      - testbench/l2RingCacheTb.sv

/* hw/cachePkg.sv */
`include "l2Params.svh"

package cachePkg;

	typedef logic [`L2_INDEX_BITS-1:0] indexT;
	typedef logic [`L2_LINE_ADDR_BITS-1:0] lineAddrT;
	typedef logic [`RING_DATA_BITS-1:0] quarterT;

	// quarter n sits at bits 128*n+127 : 128*n
	typedef quarterT [`L2_QUARTERS-1:0] lineT;

	typedef struct packed {
		logic valid;
		logic dirty;
		lineAddrT lineAddr;
	} tagEntryT;

	// miss with the victim as read from the arrays
	typedef struct packed {
		logic valid;
		indexT index;
		lineAddrT lineAddr;
		tagEntryT victimTag;
		lineT victimLine;
	} missReqT;

	typedef struct packed {
		logic valid;
		indexT index;
		tagEntryT tag;
		lineT line;
	} installT;

	typedef struct packed {
		logic [4:0] opm;
		logic [`DDR_ADDR_BITS-1:0] addr;
		lineT data;
	} ddrCmdT;

	typedef struct packed {
		logic [1:0] ok;
		lineT data;
	} ddrRspT;

	// DDR command and status codes
	localparam logic [4:0] DDR_OPM_READY = 5'h00;
	localparam logic [4:0] DDR_OPM_RD_TILE = 5'h17;
	localparam logic [4:0] DDR_OPM_WR_TILE = 5'h1B;
	localparam logic [1:0] DDR_OK_READY = 2'b00;
	localparam logic [1:0] DDR_OK_OK = 2'b01;
	localparam logic [1:0] DDR_OK_HOLD = 2'b10;

endpackage

/* hw/l2LookupStage.sv */
`include "l2Params.svh"

module l2LookupStage (
	input logic clock,
	input logic reset,
	input ringPkg::ringFlitT ringIn,
	output cachePkg::indexT readIndex,
	input cachePkg::tagEntryT tagRead,
	input cachePkg::lineT lineRead,
	output logic tagWriteEnable,
	output logic lineWriteEnable,
	output cachePkg::indexT writeIndex,
	output cachePkg::tagEntryT tagWrite,
	output cachePkg::lineT lineWrite,
	output cachePkg::missReqT missReq,
	input logic busy,
	input cachePkg::installT install,
	output logic served,
	output logic [`RING_DATA_BITS-1:0] respData
);
	import ringPkg::*;
	import cachePkg::*;

	typedef struct packed {
		indexT index;
		lineAddrT lineAddr;
		logic [1:0] quarter;
		quarterT data;
	} reqT;

	reqT reqNext;
	reqT req1;
	reqT req2;
	logic isRam;
	logic isLoadNext;
	logic isStoreNext;
	logic isLoad1;
	logic isStore1;
	logic isLoad2;
	logic isStore2;

	logic sweeping;
	indexT sweepIndex;
	logic lastWriteValid;
	indexT lastWriteIndex;
	indexT missIndex;

	logic isReq2;
	logic tagHit;
	logic hazard;
	logic storeHit;
	logic missIssue;
	lineT mergedLine;

	// cycle 0: decode the flit on the ring
	always_comb
	begin
		isRam = `L2_IS_RAM(ringIn.addr);
		reqNext.lineAddr =
			ringIn.addr[`L2_LINE_ADDR_BITS+`L2_LINE_OFFSET_BITS-1:`L2_LINE_OFFSET_BITS];
		reqNext.index = `L2_HASH(reqNext.lineAddr);
		reqNext.quarter = ringIn.addr[`L2_LINE_OFFSET_BITS-1:`L2_QUARTER_LSB];
		reqNext.data = ringIn.data;
		isLoadNext = isRam && (ringIn.opm[7:0] == OPM_LDX);
		isStoreNext = isRam && (ringIn.opm[7:0] == OPM_STX);
	end

	always_ff @(posedge clock)
	begin
		req1 <= reqNext;
		req2 <= req1;
		if (reset)
		begin
			isLoad1 <= 1'b0;
			isStore1 <= 1'b0;
			isLoad2 <= 1'b0;
			isStore2 <= 1'b0;
		end
		else
		begin
			isLoad1 <= isLoadNext;
			isStore1 <= isStoreNext;
			isLoad2 <= isLoad1;
			isStore2 <= isStore1;
		end
	end

	// cycle 1: array read address
	assign readIndex = req1.index;

	// cycle 2: compare and decide
	always_comb
	begin
		isReq2 = isLoad2 || isStore2;
		tagHit = tagRead.valid && (tagRead.lineAddr == req2.lineAddr);

		// stale read, line in flight, or install landing on this index
		hazard = sweeping
			|| (lastWriteValid && (lastWriteIndex == req2.index))
			|| (busy && (missIndex == req2.index))
			|| (install.valid && (install.index == req2.index));

		// install owns the write port this cycle
		storeHit = isStore2 && tagHit && !hazard && !install.valid;
		served = isReq2 && tagHit && !hazard && !(isStore2 && install.valid);
		missIssue = isReq2 && !tagHit && !hazard && !busy && !install.valid;

		mergedLine = lineRead;
		mergedLine[req2.quarter] = req2.data;
		respData = lineRead[req2.quarter];
	end

	always_comb
	begin
		missReq.valid = missIssue;
		missReq.index = req2.index;
		missReq.lineAddr = req2.lineAddr;
		missReq.victimTag = tagRead;
		missReq.victimLine = lineRead;
	end

	// write port: sweep, then install, then store hit
	always_comb
	begin
		tagWriteEnable = 1'b0;
		lineWriteEnable = 1'b0;
		writeIndex = req2.index;
		tagWrite.valid = 1'b1;
		tagWrite.dirty = 1'b1;
		tagWrite.lineAddr = req2.lineAddr;
		lineWrite = mergedLine;
		if (sweeping)
		begin
			tagWriteEnable = 1'b1;
			writeIndex = sweepIndex;
			tagWrite = '0;
		end
		else if (install.valid)
		begin
			tagWriteEnable = 1'b1;
			lineWriteEnable = 1'b1;
			writeIndex = install.index;
			tagWrite = install.tag;
			lineWrite = install.line;
		end
		else if (storeHit)
		begin
			tagWriteEnable = 1'b1;
			lineWriteEnable = 1'b1;
		end
	end

	always_ff @(posedge clock)
	begin
		lastWriteIndex <= writeIndex;
		if (missIssue)
		begin
			missIndex <= req2.index;
		end
		if (reset)
		begin
			sweeping <= 1'b1;
			sweepIndex <= '0;
			lastWriteValid <= 1'b0;
		end
		else
		begin
			lastWriteValid <= tagWriteEnable;
			if (sweeping)
			begin
				sweepIndex <= sweepIndex + 1'b1;
				// last entry cleared, open for requests
				if (sweepIndex == '1)
				begin
					sweeping <= 1'b0;
				end
			end
		end
	end

endmodule

/* hw/l2MissEngine.sv */
`include "l2Params.svh"

module l2MissEngine (
	input logic clock,
	input logic reset,
	input cachePkg::missReqT missReq,
	output logic busy,
	output cachePkg::installT install,
	output cachePkg::ddrCmdT ddrCmd,
	input cachePkg::ddrRspT ddrRsp
);
	import cachePkg::*;

	typedef enum logic [2:0] {
		stIdle,
		stWriteBack,
		stWbWaitReady,
		stRead,
		stRdWaitReady,
		stInstall
	} stateT;

	stateT state;
	missReqT pending;
	lineT fillLine;

	function automatic logic [`DDR_ADDR_BITS-1:0] lineToDdr(input lineAddrT lineAddr);
		return {lineAddr, {`L2_LINE_OFFSET_BITS{1'b0}}};
	endfunction

	// busy drops together with the install pulse
	assign busy = (state != stIdle) && (state != stInstall);

	always_comb
	begin
		install.valid = (state == stInstall);
		install.index = pending.index;
		install.tag.valid = 1'b1;
		install.tag.dirty = 1'b0;
		install.tag.lineAddr = pending.lineAddr;
		install.line = fillLine;
	end

	// a command stays on the port until OK, HOLD just keeps it there
	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			state <= stIdle;
			ddrCmd.opm <= DDR_OPM_READY;
		end
		else
		begin
			case (state)
				stIdle:
				begin
					if (missReq.valid)
					begin
						pending <= missReq;
						if (missReq.victimTag.valid && missReq.victimTag.dirty)
						begin
							ddrCmd.opm <= DDR_OPM_WR_TILE;
							ddrCmd.addr <= lineToDdr(missReq.victimTag.lineAddr);
							ddrCmd.data <= missReq.victimLine;
							state <= stWriteBack;
						end
						else
						begin
							ddrCmd.opm <= DDR_OPM_RD_TILE;
							ddrCmd.addr <= lineToDdr(missReq.lineAddr);
							state <= stRead;
						end
					end
				end
				stWriteBack:
				begin
					if (ddrRsp.ok == DDR_OK_OK)
					begin
						ddrCmd.opm <= DDR_OPM_READY;
						state <= stWbWaitReady;
					end
				end
				stWbWaitReady:
				begin
					if (ddrRsp.ok == DDR_OK_READY)
					begin
						ddrCmd.opm <= DDR_OPM_RD_TILE;
						ddrCmd.addr <= lineToDdr(pending.lineAddr);
						state <= stRead;
					end
				end
				stRead:
				begin
					// read data only valid alongside OK
					if (ddrRsp.ok == DDR_OK_OK)
					begin
						fillLine <= ddrRsp.data;
						ddrCmd.opm <= DDR_OPM_READY;
						state <= stRdWaitReady;
					end
				end
				stRdWaitReady:
				begin
					if (ddrRsp.ok == DDR_OK_READY)
					begin
						state <= stInstall;
					end
				end
				stInstall:
				begin
					state <= stIdle;
				end
				default:
				begin
					state <= stIdle;
				end
			endcase
		end
	end

endmodule

/* hw/l2Params.svh */
`ifndef L2_PARAMS_SVH
`define L2_PARAMS_SVH

// cache geometry, one line per index
`define L2_INDEX_BITS 6
`define L2_LINE_ADDR_BITS 26
`define L2_LINE_OFFSET_BITS 6
`define L2_QUARTERS 4
`define L2_QUARTER_LSB 4

// bus widths
`define RING_ADDR_BITS 48
`define RING_DATA_BITS 128
`define DDR_ADDR_BITS 32

// RAM window: bits 31:30 clear, bits 29:24 nonzero
`define L2_IS_RAM(a) ((a[31:30] == 2'b00) && (a[29:24] != 6'h00))

// low index bits of the line address folded with the next ones
`define L2_HASH(la) (la[`L2_INDEX_BITS-1:0] ^ la[2*`L2_INDEX_BITS-1:`L2_INDEX_BITS])

`endif

/* hw/l2RingCache.sv */
`include "l2Params.svh"

module l2RingCache (
	input logic clock,
	input logic reset,
	input ringPkg::ringFlitT ringIn,
	output ringPkg::ringFlitT ringOut,
	output cachePkg::ddrCmdT ddrCmd,
	input cachePkg::ddrRspT ddrRsp
);
	import cachePkg::*;

	indexT readIndex;
	indexT writeIndex;
	tagEntryT tagRead;
	tagEntryT tagWrite;
	lineT lineRead;
	lineT lineWrite;
	logic tagWriteEnable;
	logic lineWriteEnable;
	missReqT missReq;
	installT install;
	logic busy;
	logic served;
	logic [`RING_DATA_BITS-1:0] respData;

	l2LookupStage u_lookup (
		.clock(clock),
		.reset(reset),
		.ringIn(ringIn),
		.readIndex(readIndex),
		.tagRead(tagRead),
		.lineRead(lineRead),
		.tagWriteEnable(tagWriteEnable),
		.lineWriteEnable(lineWriteEnable),
		.writeIndex(writeIndex),
		.tagWrite(tagWrite),
		.lineWrite(lineWrite),
		.missReq(missReq),
		.busy(busy),
		.install(install),
		.served(served),
		.respData(respData)
	);

	// tags and lines share the index, written by separate enables
	tileArray #(.entryT(tagEntryT)) u_tagArray (
		.clock(clock),
		.readIndex(readIndex),
		.readEntry(tagRead),
		.writeEnable(tagWriteEnable),
		.writeIndex(writeIndex),
		.writeEntry(tagWrite)
	);

	tileArray #(.entryT(lineT)) u_lineArray (
		.clock(clock),
		.readIndex(readIndex),
		.readEntry(lineRead),
		.writeEnable(lineWriteEnable),
		.writeIndex(writeIndex),
		.writeEntry(lineWrite)
	);

	l2MissEngine u_missEngine (
		.clock(clock),
		.reset(reset),
		.missReq(missReq),
		.busy(busy),
		.install(install),
		.ddrCmd(ddrCmd),
		.ddrRsp(ddrRsp)
	);

	l2RingResponder u_responder (
		.clock(clock),
		.reset(reset),
		.ringIn(ringIn),
		.served(served),
		.respData(respData),
		.ringOut(ringOut)
	);

endmodule

/* hw/l2RingResponder.sv */
`include "l2Params.svh"

module l2RingResponder (
	input logic clock,
	input logic reset,
	input ringPkg::ringFlitT ringIn,
	input logic served,
	input logic [`RING_DATA_BITS-1:0] respData,
	output ringPkg::ringFlitT ringOut
);
	import ringPkg::*;

	localparam ringFlitT idleFlit = '{
		seq: '0,
		opm: {8'h00, OPM_IDLE},
		addr: '0,
		data: '0
	};

	ringFlitT flitD1;
	ringFlitT flitD2;
	ringFlitT response;

	// flitD2 lines up with the lookup result
	always_comb
	begin
		response = flitD2;
		if (served)
		begin
			if (flitD2.opm[7:0] == OPM_STX)
			begin
				response.opm[7:0] = OPM_OKST;
			end
			else
			begin
				response.opm[7:0] = OPM_OKLD;
				response.data = respData;
			end
			// requester tag back into the low nibble
			response.opm[3:0] = flitD2.opm[11:8];
		end
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			flitD1 <= idleFlit;
			flitD2 <= idleFlit;
			ringOut <= idleFlit;
		end
		else
		begin
			flitD1 <= ringIn;
			flitD2 <= flitD1;
			ringOut <= response;
		end
	end

endmodule

/* hw/ringPkg.sv */
`include "l2Params.svh"

package ringPkg;

	// one ring slot, moves every cycle
	typedef struct packed {
		logic [15:0] seq;
		logic [15:0] opm;
		logic [`RING_ADDR_BITS-1:0] addr;
		logic [`RING_DATA_BITS-1:0] data;
	} ringFlitT;

	// opcodes live in opm[7:0]
	localparam logic [7:0] OPM_IDLE = 8'h00;
	localparam logic [7:0] OPM_LDX = 8'h93;
	localparam logic [7:0] OPM_STX = 8'h97;

	// responses, bits 7:6 = 01, low nibble carries the requester tag
	localparam logic [7:0] OPM_OKLD = 8'h60;
	localparam logic [7:0] OPM_OKST = 8'h70;

endpackage

/* hw/tileArray.sv */
`include "l2Params.svh"

module tileArray #(
	parameter type entryT = logic,
	parameter int indexBits = `L2_INDEX_BITS
) (
	input logic clock,
	input logic [indexBits-1:0] readIndex,
	output entryT readEntry,
	input logic writeEnable,
	input logic [indexBits-1:0] writeIndex,
	input entryT writeEntry
);

	localparam int depth = 1 << indexBits;

	entryT mem [0:depth-1];

	// read returns the old entry when both ports hit one index
	always_ff @(posedge clock)
	begin
		if (writeEnable)
		begin
			mem[writeIndex] <= writeEntry;
		end
		readEntry <= mem[readIndex];
	end

endmodule

/* tb.f */
+incdir+hw
hw/ringPkg.sv
hw/cachePkg.sv
hw/tileArray.sv
hw/l2LookupStage.sv
hw/l2MissEngine.sv
hw/l2RingResponder.sv
hw/l2RingCache.sv
testbench/ddrTileModel.sv
testbench/l2RingCacheTb.sv

/* testbench/ddrTileModel.sv */
`include "l2Params.svh"

module ddrTileModel (
	input logic clock,
	input logic reset,
	input cachePkg::ddrCmdT ddrCmd,
	output cachePkg::ddrRspT ddrRsp
);
	import cachePkg::*;

	typedef enum logic [1:0] {
		modelIdle,
		modelHold,
		modelDone
	} modelStateT;

	modelStateT state = modelIdle;
	ddrRspT response = '0;
	lineT backing [lineAddrT];
	logic [31:0] lfsr = 32'h7b52_3c38;
	int holdLeft = 0;
	int holdDraw;

	assign ddrRsp = response;

	// taps for x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsrStep(input logic [31:0] s);
		if (s[0])
		begin
			return (s >> 1) ^ 32'h8020_0003;
		end
		return s >> 1;
	endfunction

	// untouched lines hold line address times a constant, per quarter
	function automatic quarterT patternQuarter(input lineAddrT lineAddr, input logic [1:0] q);
		logic [31:0] word;
		word = {6'h00, lineAddr} * 32'h9e37_79b1 + 32'(q);
		return {word, ~word, word ^ 32'h5a5a_5a5a, 30'h0, q};
	endfunction

	function automatic lineT readLine(input lineAddrT lineAddr);
		lineT line;
		if (backing.exists(lineAddr))
		begin
			return backing[lineAddr];
		end
		for (int q = 0; q < `L2_QUARTERS; q++)
		begin
			line[q] = patternQuarter(lineAddr, 2'(q));
		end
		return line;
	endfunction

	// 0 to 3 HOLD cycles, one step per bit
	task automatic drawHold(output int n);
		n = 0;
		repeat (2)
		begin
			lfsr = lfsrStep(lfsr);
			n = n * 2 + int'(lfsr[0]);
		end
	endtask

	task automatic serve();
		lineAddrT lineAddr;
		lineAddr = ddrCmd.addr[`DDR_ADDR_BITS-1:`L2_LINE_OFFSET_BITS];
		if (ddrCmd.opm == DDR_OPM_WR_TILE)
		begin
			backing[lineAddr] = ddrCmd.data;
		end
		else
		begin
			response.data <= readLine(lineAddr);
		end
		response.ok <= DDR_OK_OK;
	endtask

	always @(posedge clock)
	begin
		if (reset)
		begin
			state <= modelIdle;
			response <= '0;
			lfsr = 32'h7b52_3c38;
		end
		else
		begin
			case (state)
				modelIdle:
				begin
					if (ddrCmd.opm != DDR_OPM_READY)
					begin
						drawHold(holdDraw);
						if (holdDraw == 0)
						begin
							serve();
							state <= modelDone;
						end
						else
						begin
							response.ok <= DDR_OK_HOLD;
							holdLeft <= holdDraw;
							state <= modelHold;
						end
					end
				end
				modelHold:
				begin
					if (holdLeft == 1)
					begin
						serve();
						state <= modelDone;
					end
					else
					begin
						holdLeft <= holdLeft - 1;
					end
				end
				default:
				begin
					// OK stays up until the command is withdrawn
					if (ddrCmd.opm == DDR_OPM_READY)
					begin
						response.ok <= DDR_OK_READY;
						state <= modelIdle;
					end
				end
			endcase
		end
	end

endmodule

/* testbench/l2RingCacheTb.sv */
`include "l2Params.svh"

module l2RingCacheTb;
	import ringPkg::*;
	import cachePkg::*;

	typedef struct packed {
		logic isStore;
		logic [31:0] addr;
		quarterT data;
		quarterT expected;
	} rowT;

	localparam int numRows = 10;
	localparam int cycleLimit = numRows * 200;
	// A and B fold to the same index
	localparam logic [31:0] addrA = 32'h0100_0000;
	localparam logic [31:0] addrB = 32'h0100_1040;
	localparam logic [31:0] addrC = 32'h2a00_0340;
	localparam quarterT dataOne = 128'h0123_4567_89ab_cdef_fedc_ba98_7654_3210;
	localparam quarterT dataTwo = 128'h1111_2222_3333_4444_5555_6666_7777_8888;
	localparam ringFlitT idleFlit = '0;

	logic clock;
	logic reset;
	ringFlitT ringIn;
	ringFlitT ringOut;
	ddrCmdT ddrCmd;
	ddrRspT ddrRsp;

	rowT rows [numRows];
	ringFlitT history [$];
	quarterT refMem [logic [31:0]];
	ddrCmdT heldCmd;
	logic cmdPending = 1'b0;
	int errors = 0;
	int checks = 0;
	int writeBacks = 0;
	int cycles = 0;

	l2RingCache u_l2RingCache (
		.clock(clock),
		.reset(reset),
		.ringIn(ringIn),
		.ringOut(ringOut),
		.ddrCmd(ddrCmd),
		.ddrRsp(ddrRsp)
	);

	ddrTileModel u_ddrTileModel (
		.clock(clock),
		.reset(reset),
		.ddrCmd(ddrCmd),
		.ddrRsp(ddrRsp)
	);

	initial
	begin
		clock = 1'b0;
		forever #2 clock = ~clock;
	end

	function automatic quarterT patternQuarter(input lineAddrT lineAddr, input logic [1:0] q);
		logic [31:0] word;
		word = {6'h00, lineAddr} * 32'h9e37_79b1 + 32'(q);
		return {word, ~word, word ^ 32'h5a5a_5a5a, 30'h0, q};
	endfunction

	function automatic quarterT readRef(input logic [31:0] addr);
		if (refMem.exists({addr[31:4], 4'h0}))
		begin
			return refMem[{addr[31:4], 4'h0}];
		end
		return patternQuarter(addr[31:6], addr[5:4]);
	endfunction

	function automatic ringFlitT makeFlit(input logic [15:0] seq, input logic [15:0] opm,
		input logic [31:0] addr, input quarterT data);
		ringFlitT flit;
		flit.seq = seq;
		flit.opm = opm;
		flit.addr = {16'h0000, addr};
		flit.data = data;
		return flit;
	endfunction

	function automatic logic canServe(input ringFlitT flit);
		return `L2_IS_RAM(flit.addr)
			&& ((flit.opm[7:0] == OPM_LDX) || (flit.opm[7:0] == OPM_STX));
	endfunction

	function automatic logic isResponse(input ringFlitT flit);
		return (flit.opm[7:4] == OPM_OKLD[7:4]) || (flit.opm[7:4] == OPM_OKST[7:4]);
	endfunction

	// output flit against the flit sent 3 cycles earlier
	task automatic checkOutput(input ringFlitT sent, input ringFlitT got);
		ringFlitT expected;
		logic answered;
		expected = sent;
		answered = canServe(sent) && isResponse(got);
		if (answered && (sent.opm[7:0] == OPM_STX))
		begin
			expected.opm[7:0] = {OPM_OKST[7:4], sent.opm[11:8]};
			refMem[{sent.addr[31:4], 4'h0}] = sent.data;
		end
		else if (answered)
		begin
			expected.opm[7:0] = {OPM_OKLD[7:4], sent.opm[11:8]};
			expected.data = readRef(sent.addr[31:0]);
		end
		checks++;
		assert (got == expected)
		else
		begin
			errors++;
			$display("FAILED at %0t: seq %h got opm %h data %h, expected opm %h data %h",
				$time, sent.seq, got.opm, got.data, expected.opm, expected.data);
		end
	endtask

	task automatic advance(output ringFlitT got);
		@(posedge clock);
		#1;
		got = ringOut;
		if (history.size() == 3)
		begin
			checkOutput(history.pop_front(), got);
		end
	endtask

	task automatic drive(input ringFlitT flit);
		ringIn = flit;
		history.push_back(flit);
	endtask

	// non-RAM, empty window and idle flits
	task automatic sendPassThrough();
		ringFlitT got;
		drive(makeFlit(16'h0a01, {8'h05, OPM_LDX}, 32'h4100_0000, {4{32'ha5a5_0001}}));
		advance(got);
		drive(makeFlit(16'h0a02, {8'h0c, OPM_STX}, 32'h0000_1230, {4{32'h3c3c_0002}}));
		advance(got);
		drive(makeFlit(16'h0a03, {8'h07, OPM_IDLE}, addrA, {4{32'h0f0f_0003}}));
		advance(got);
	endtask

	// resend every 3 cycles until the cache answers
	task automatic runRow(input int r);
		ringFlitT req;
		ringFlitT got;
		logic [7:0] op;
		logic done;
		op = rows[r].isStore ? OPM_STX : OPM_LDX;
		req = makeFlit(16'h0100 + 16'(r), {4'h0, 4'(r + 1), op}, rows[r].addr, rows[r].data);
		done = 1'b0;
		drive(req);
		while (!done)
		begin
			advance(got);
			drive(idleFlit);
			advance(got);
			drive(idleFlit);
			advance(got);
			if (isResponse(got))
			begin
				done = 1'b1;
				checks++;
				assert (got.data == rows[r].expected)
				else
				begin
					errors++;
					$display("FAILED at %0t: row %0d returned %h, table expects %h",
						$time, r, got.data, rows[r].expected);
				end
			end
			else
			begin
				drive(req);
			end
		end
	endtask

	task automatic checkWriteBack();
		lineT expected;
		logic stored;
		stored = 1'b0;
		for (int q = 0; q < `L2_QUARTERS; q++)
		begin
			expected[q] = readRef({ddrCmd.addr[31:6], 2'(q), 4'h0});
			if (refMem.exists({ddrCmd.addr[31:6], 2'(q), 4'h0}))
			begin
				stored = 1'b1;
			end
		end
		writeBacks++;
		checks += 2;
		// only a line that took a store can be dirty
		assert (stored)
		else
		begin
			errors++;
			$display("FAILED at %0t: write back to %h, a line that never took a store",
				$time, ddrCmd.addr);
		end
		assert (ddrCmd.data == expected)
		else
		begin
			errors++;
			$display("FAILED at %0t: write back to %h carries %h, expected %h",
				$time, ddrCmd.addr, ddrCmd.data, expected);
		end
	endtask

	// DDR command must not move until OK
	always @(posedge clock)
	begin
		if (reset)
		begin
			cmdPending = 1'b0;
		end
		else
		begin
			if (cmdPending)
			begin
				checks++;
				assert (ddrCmd === heldCmd)
				else
				begin
					errors++;
					$display("FAILED at %0t: DDR command changed before OK", $time);
				end
			end
			if ((ddrCmd.opm == DDR_OPM_WR_TILE) && (ddrRsp.ok == DDR_OK_OK))
			begin
				checkWriteBack();
			end
			heldCmd = ddrCmd;
			cmdPending = (ddrCmd.opm != DDR_OPM_READY) && (ddrRsp.ok != DDR_OK_OK);
		end
	end

	always @(posedge clock)
	begin
		cycles++;
		if (cycles >= cycleLimit)
		begin
			$display("timeout: the table did not finish within %0d cycles", cycleLimit);
			$display("TESTS FAILED");
			$finish;
		end
	end

	initial
	begin
		ringFlitT got;
		reset = 1'b1;
		ringIn = idleFlit;
		rows[0] = '{1'b0, addrA, '0, patternQuarter(addrA[31:6], 2'd0)};
		rows[1] = '{1'b0, addrA + 32'h10, '0, patternQuarter(addrA[31:6], 2'd1)};
		rows[2] = '{1'b1, addrA + 32'h10, dataOne, dataOne};
		rows[3] = '{1'b0, addrA + 32'h10, '0, dataOne};
		rows[4] = '{1'b0, addrA + 32'h20, '0, patternQuarter(addrA[31:6], 2'd2)};
		// B evicts the dirty A line
		rows[5] = '{1'b0, addrB + 32'h10, '0, patternQuarter(addrB[31:6], 2'd1)};
		rows[6] = '{1'b0, addrA + 32'h10, '0, dataOne};
		rows[7] = '{1'b1, addrB + 32'h30, dataTwo, dataTwo};
		rows[8] = '{1'b0, addrB + 32'h30, '0, dataTwo};
		rows[9] = '{1'b0, addrC, '0, patternQuarter(addrC[31:6], 2'd0)};
		repeat (8) @(posedge clock);
		#1;
		reset = 1'b0;
		advance(got);
		sendPassThrough();
		for (int r = 0; r < numRows; r++)
		begin
			runRow(r);
		end
		sendPassThrough();
		repeat (3)
		begin
			drive(idleFlit);
			advance(got);
		end
		checks++;
		assert (writeBacks > 0)
		else
		begin
			errors++;
			$display("no dirty line was written back to DDR");
		end
		$display("checks %0d, errors %0d, write backs %0d", checks, errors, writeBacks);
		if (errors == 0)
		begin
			$display("TESTS PASSED");
		end
		else
		begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule
